/* Bender.yml */
package:
  name: axil_ram

sources:
  # Design, in compile order
  - axil_ram_pkg.sv
  - ram_wr_if.sv
  - req_fifo.sv
  - write_path.sv
  - read_path.sv
  - line_ram.sv
  - axil_ram.sv
  # Testbench
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_axil_ram.sv

/* axil_ram.sv */
// AXI4-lite RAM top level with wide internal lines
// Connects the write path, the read path and the line memory

`timescale 1ns/1ps
`default_nettype none

module axil_ram
    import axil_ram_pkg::*;
#(
    parameter int ADDR_W       = axil_ram_pkg::ADDR_W,
    parameter int ID_W         = axil_ram_pkg::ID_W,
    parameter int OSTD_REQ_NUM = axil_ram_pkg::OSTD_REQ_NUM
) (
    input  logic              aclk,
    input  logic              aresetn,
    // Write address
    input  logic              awvalid,
    output logic              awready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic [ID_W-1:0]   awid,
    // Write data
    input  logic              wvalid,
    output logic              wready,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    // Write response
    output logic              bvalid,
    input  logic              bready,
    output logic [ID_W-1:0]   bid,
    // Read address
    input  logic              arvalid,
    output logic              arready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic [ID_W-1:0]   arid,
    // Read data
    output logic              rvalid,
    input  logic              rready,
    output logic [ID_W-1:0]   rid,
    output logic [DATA_W-1:0] rdata
);

    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;

    ram_wr_if #(.ADDR_W (ADDR_W)) wr_bus ();

    ////////////////////////////////////////
    // Request queues and responses
    ////////////////////////////////////////

    write_path #(
        .ADDR_W       (ADDR_W),
        .ID_W         (ID_W),
        .OSTD_REQ_NUM (OSTD_REQ_NUM)
    ) u_write_path (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awid    (awid),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bid     (bid),
        .wr      (wr_bus.src)
    );

    read_path #(
        .ADDR_W       (ADDR_W),
        .ID_W         (ID_W),
        .OSTD_REQ_NUM (OSTD_REQ_NUM)
    ) u_read_path (
        .aclk    (aclk),
        .aresetn (aresetn),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arid    (arid),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ////////////////////////////////////////
    // Memory
    ////////////////////////////////////////

    line_ram #(
        .ADDR_W (ADDR_W)
    ) u_line_ram (
        .aclk    (aclk),
        .wr      (wr_bus.dst),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* axil_ram_pkg.sv */
// Shared widths, parameter defaults and the RAM line type of the AXI4-lite line RAM
// Imported with a wildcard by every design unit that needs one of these names

`default_nettype none

package axil_ram_pkg;

    ////////////////////////////////////////
    // Defaults for the module parameters
    ////////////////////////////////////////

    // Byte address width
    localparam int ADDR_W       = 8;
    localparam int ID_W         = 4;
    // Depth of every request FIFO
    localparam int OSTD_REQ_NUM = 4;

    ////////////////////////////////////////
    // Fixed geometry
    ////////////////////////////////////////

    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int LINE_W     = 128;
    localparam int LANES      = LINE_W / DATA_W;
    localparam int LINE_BYTES = LINE_W / 8;
    localparam int LANE_SEL_W = $clog2(LANES);
    // Line index sits above the byte offset inside a line
    localparam int LINE_SEL_W = ADDR_W - $clog2(LINE_BYTES);

    // One RAM line
    // Word view picks a lane on reads, byte view takes strobed writes
    typedef union packed {
        logic [LANES-1:0][DATA_W-1:0] words;
        logic [LINE_BYTES-1:0][7:0]   bytes;
    } ram_line_u;

endpackage

`default_nettype wire

/* line_ram.sv */
// Wide-line memory with 32-bit lanes inside 128-bit lines
// Strobed writes from the commit bus, combinational lane reads

`timescale 1ns/1ps
`default_nettype none

module line_ram
    import axil_ram_pkg::*;
#(
    parameter int ADDR_W = axil_ram_pkg::ADDR_W
) (
    input  logic              aclk,
    ram_wr_if.dst             wr,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    // Byte offset inside a word, then lane, then line
    localparam int WORD_OFF_W = $clog2(STRB_W);
    localparam int LINE_OFF_W = WORD_OFF_W + LANE_SEL_W;

    ram_line_u mem [2**LINE_SEL_W];

    logic [LINE_SEL_W-1:0] wr_line;
    logic [LANE_SEL_W-1:0] wr_lane;
    logic [LINE_SEL_W-1:0] rd_line;
    logic [LANE_SEL_W-1:0] rd_lane;
    ram_line_u             rd_word_line;

    assign wr_line = wr.wr_addr[LINE_OFF_W +: LINE_SEL_W];
    assign wr_lane = wr.wr_addr[WORD_OFF_W +: LANE_SEL_W];
    assign rd_line = rd_addr[LINE_OFF_W +: LINE_SEL_W];
    assign rd_lane = rd_addr[WORD_OFF_W +: LANE_SEL_W];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    // Only strobed bytes of the selected lane change
    always_ff @(posedge aclk) begin
        if (wr.wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr.wr_strb[b]) begin
                    mem[wr_line].bytes[wr_lane * STRB_W + b] <= wr.wr_data[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    assign rd_word_line = mem[rd_line];
    assign rd_data      = rd_word_line.words[rd_lane];

endmodule

`default_nettype wire

/* ram_wr_if.sv */
// Write commit bus from the write path to the line RAM
// The write path drives it as src, the RAM samples it as dst

`timescale 1ns/1ps
`default_nettype none

interface ram_wr_if
    import axil_ram_pkg::*;
#(
    parameter int ADDR_W = axil_ram_pkg::ADDR_W
);

    // One-cycle commit strobe
    logic              wr_en;
    // Byte address, selects line and lane
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;

    modport src (output wr_en, output wr_addr, output wr_data, output wr_strb);

    modport dst (input wr_en, input wr_addr, input wr_data, input wr_strb);

endinterface

`default_nettype wire

/* read_path.sv */
// AXI4-lite read side that queues AR requests and answers the oldest one
// with the addressed RAM word and its ID, in order

`timescale 1ns/1ps
`default_nettype none

module read_path
    import axil_ram_pkg::*;
#(
    parameter int ADDR_W       = axil_ram_pkg::ADDR_W,
    parameter int ID_W         = axil_ram_pkg::ID_W,
    parameter int OSTD_REQ_NUM = axil_ram_pkg::OSTD_REQ_NUM
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              arvalid,
    output logic              arready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic [ID_W-1:0]   arid,
    output logic              rvalid,
    input  logic              rready,
    output logic [ID_W-1:0]   rid,
    output logic [DATA_W-1:0] rdata,
    output logic [ADDR_W-1:0] rd_addr,
    input  logic [DATA_W-1:0] rd_data
);

    logic ar_full;
    logic ar_empty;

    ////////////////////////////////////////
    // Request queue
    ////////////////////////////////////////

    assign arready = !ar_full;

    req_fifo #(
        .WIDTH (ID_W + ADDR_W),
        .DEPTH (OSTD_REQ_NUM)
    ) u_ar_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (arvalid && arready),
        .data_in  ({arid, araddr}),
        .full     (ar_full),
        .pull     (rvalid && rready),
        .data_out ({rid, rd_addr}),
        .empty    (ar_empty)
    );

    ////////////////////////////////////////
    // Response
    ////////////////////////////////////////

    // Head address looks up the RAM combinationally, so data
    // is ready the cycle after the request lands in the queue
    assign rvalid = !ar_empty;
    assign rdata  = rd_data;

    // Head stays put while the master stalls
    r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rid));

endmodule

`default_nettype wire

/* req_fifo.sv */
// Single-clock circular FIFO for accepted AXI requests
// Head entry is always visible on data_out while not empty

`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    output logic             full,
    input  logic             pull,
    output logic [WIDTH-1:0] data_out,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap explicitly so a depth that is not a power of two still works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pull) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign data_out = mem[rd_ptr];
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

    // Owners gate push with full and pull with empty
    no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
        push |-> !full);

    no_pull_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        pull |-> !empty);

endmodule

`default_nettype wire

/* tb_axil_ram.sv */
// Table-driven testbench for the AXI4-lite line RAM
// Applies the stimulus table in order and checks every response against a byte model

`timescale 1ns/1ps
`default_nettype none

module tb_axil_ram
    import axil_ram_pkg::*;
();

    localparam int NUM_ENTRIES = 27;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 40 + 100;
    localparam int DRIVE_DLY   = 1;
    localparam int WAIT_CAP    = 16;
    localparam int OP_WR       = 0;
    localparam int OP_RD       = 1;
    // Writes issued while bready is held low
    localparam int OP_WR_HELD  = 2;
    // Reads issued back to back while rready is held low
    localparam int OP_RD_HELD  = 3;

    logic              aclk;
    logic              aresetn;
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic [ID_W-1:0]   awid;
    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bvalid;
    logic              bready;
    logic [ID_W-1:0]   bid;
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic [ID_W-1:0]   arid;
    logic              rvalid;
    logic              rready;
    logic [ID_W-1:0]   rid;
    logic [DATA_W-1:0] rdata;

    // Stimulus table with one column per array
    string             ent_name    [NUM_ENTRIES];
    int                ent_op      [NUM_ENTRIES];
    logic [ADDR_W-1:0] ent_addr    [NUM_ENTRIES];
    logic [DATA_W-1:0] ent_data    [NUM_ENTRIES];
    logic [STRB_W-1:0] ent_strb    [NUM_ENTRIES];
    logic [ID_W-1:0]   ent_id      [NUM_ENTRIES];
    logic              ent_has_exp [NUM_ENTRIES];
    logic [DATA_W-1:0] ent_exp     [NUM_ENTRIES];
    int                num_added   = 0;

    // Flat byte image of the RAM as the bus sees it
    logic [7:0]        ref_mem [2**ADDR_W];

    int                errors      = 0;
    int                tests_run   = 0;
    int                cycle_count = 0;

    tb_clk_gen #(.PERIOD (4)) u_clk_gen (.aclk (aclk));

    axil_ram #(
        .ADDR_W       (ADDR_W),
        .ID_W         (ID_W),
        .OSTD_REQ_NUM (OSTD_REQ_NUM)
    ) u_dut (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awid    (awid),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bid     (bid),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arid    (arid),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata)
    );

    ////////////////////////////////////////
    // Table and reference model
    ////////////////////////////////////////

    task automatic add_entry(input string name, input int op,
                             input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb, input logic [ID_W-1:0] id,
                             input logic has_exp, input logic [DATA_W-1:0] exp_word);
        ent_name[num_added]    = name;
        ent_op[num_added]      = op;
        ent_addr[num_added]    = addr;
        ent_data[num_added]    = data;
        ent_strb[num_added]    = strb;
        ent_id[num_added]      = id;
        ent_has_exp[num_added] = has_exp;
        ent_exp[num_added]     = exp_word;
        num_added++;
    endtask

    task automatic fill_table();
        add_entry("wr_full",       OP_WR,      8'h10, 32'ha5a5_1234, 4'hf, 4'h3, 1'b0, '0);
        add_entry("rd_full",       OP_RD,      8'h10, '0, '0, 4'h5, 1'b1, 32'ha5a5_1234);
        // Four lanes of one line
        add_entry("wr_lane0",      OP_WR,      8'h40, 32'h1111_0000, 4'hf, 4'h1, 1'b0, '0);
        add_entry("wr_lane1",      OP_WR,      8'h44, 32'h2222_0001, 4'hf, 4'h2, 1'b0, '0);
        add_entry("wr_lane2",      OP_WR,      8'h48, 32'h3333_0002, 4'hf, 4'h4, 1'b0, '0);
        add_entry("wr_lane3",      OP_WR,      8'h4c, 32'h4444_0003, 4'hf, 4'h6, 1'b0, '0);
        add_entry("rd_lane0",      OP_RD,      8'h40, '0, '0, 4'h7, 1'b0, '0);
        add_entry("rd_lane1",      OP_RD,      8'h44, '0, '0, 4'h8, 1'b0, '0);
        add_entry("rd_lane2",      OP_RD,      8'h48, '0, '0, 4'h9, 1'b0, '0);
        add_entry("rd_lane3",      OP_RD,      8'h4c, '0, '0, 4'ha, 1'b0, '0);
        add_entry("wr_lane2_new",  OP_WR,      8'h48, 32'hbeef_cafe, 4'hf, 4'hb, 1'b0, '0);
        add_entry("rd_lane1_keep", OP_RD,      8'h44, '0, '0, 4'hc, 1'b0, '0);
        add_entry("rd_lane2_new",  OP_RD,      8'h48, '0, '0, 4'hd, 1'b0, '0);
        add_entry("rd_lane3_keep", OP_RD,      8'h4c, '0, '0, 4'he, 1'b0, '0);
        // Partial strobes over a known word
        add_entry("wr_part_base",  OP_WR,      8'h80, 32'h0123_4567, 4'hf, 4'h0, 1'b0, '0);
        add_entry("wr_part_b0",    OP_WR,      8'h80, 32'hffff_ff99, 4'h1, 4'h1, 1'b0, '0);
        add_entry("rd_part_b0",    OP_RD,      8'h80, '0, '0, 4'h2, 1'b0, '0);
        add_entry("wr_part_hi",    OP_WR,      8'h80, 32'hab00_cd00, 4'ha, 4'h3, 1'b0, '0);
        add_entry("rd_part_hi",    OP_RD,      8'h80, '0, '0, 4'h4, 1'b0, '0);
        // Response back-pressure
        add_entry("hold_wr0",      OP_WR_HELD, 8'hc0, 32'h5a5a_0000, 4'hf, 4'h5, 1'b0, '0);
        add_entry("hold_wr1",      OP_WR_HELD, 8'hc4, 32'h5a5a_1111, 4'hf, 4'h6, 1'b0, '0);
        add_entry("hold_wr2",      OP_WR_HELD, 8'hc8, 32'h5a5a_2222, 4'hf, 4'h7, 1'b0, '0);
        add_entry("hold_wr3",      OP_WR_HELD, 8'hd0, 32'h5a5a_3333, 4'hf, 4'h8, 1'b0, '0);
        add_entry("hold_rd0",      OP_RD_HELD, 8'hc0, '0, '0, 4'h9, 1'b0, '0);
        add_entry("hold_rd1",      OP_RD_HELD, 8'hc4, '0, '0, 4'ha, 1'b0, '0);
        add_entry("hold_rd2",      OP_RD_HELD, 8'hc8, '0, '0, 4'hb, 1'b0, '0);
        add_entry("hold_rd3",      OP_RD_HELD, 8'hd0, '0, '0, 4'hc, 1'b0, '0);
    endtask

    // Strobed bytes of the addressed word take the new data
    task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic [STRB_W-1:0] strb);
        int base;
        base = int'(addr) & ~(STRB_W - 1);
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                ref_mem[base + b] = data[8*b +: 8];
            end
        end
    endtask

    function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        int                base;
        base = int'(addr) & ~(STRB_W - 1);
        for (int b = 0; b < STRB_W; b++) begin
            word[8*b +: 8] = ref_mem[base + b];
        end
        return word;
    endfunction

    function automatic logic [DATA_W-1:0] expected_word(input int idx);
        if (ent_has_exp[idx]) begin
            return ent_exp[idx];
        end
        return model_word(ent_addr[idx]);
    endfunction

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////

    task automatic report_mismatch(input string name, input string what,
                                   input logic [DATA_W-1:0] exp_val,
                                   input logic [DATA_W-1:0] act_val);
        errors++;
        $display("[FAIL] %s: %s expected %h, actual %h", name, what, exp_val, act_val);
    endtask

    task automatic report_error(input string name, input string msg);
        errors++;
        $display("ERROR in %s: %s", name, msg);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("[PASS] %s", name);
        end else begin
            $display("[DONE] %s with %0d failed check(s)", name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////
    // Bus helpers
    ////////////////////////////////////////

    // Inputs change and outputs are sampled a short delay after the edge
    task automatic tick();
        @(posedge aclk);
        #DRIVE_DLY;
    endtask

    task automatic send_write(input int idx, output logic ok);
        int waited;
        waited  = 0;
        awvalid = 1'b1;
        awaddr  = ent_addr[idx];
        awid    = ent_id[idx];
        wvalid  = 1'b1;
        wdata   = ent_data[idx];
        wstrb   = ent_strb[idx];
        while (!(awready && wready) && waited < WAIT_CAP) begin
            tick();
            waited++;
        end
        ok = awready && wready;
        if (ok) begin
            tick();
            model_write(ent_addr[idx], ent_data[idx], ent_strb[idx]);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic send_read(input int idx, output logic ok);
        int waited;
        waited  = 0;
        arvalid = 1'b1;
        araddr  = ent_addr[idx];
        arid    = ent_id[idx];
        while (!arready && waited < WAIT_CAP) begin
            tick();
            waited++;
        end
        ok = arready;
        if (ok) begin
            tick();
        end
        arvalid = 1'b0;
    endtask

    // Random bready until the response handshake
    task automatic collect_bresp(input int idx, input int errs_before);
        logic done;
        done = 1'b0;
        while (!done) begin
            bready = ($urandom % 4) != 0;
            if (bvalid && bready) begin
                if (bid !== ent_id[idx]) begin
                    report_mismatch(ent_name[idx], "bid", ent_id[idx], bid);
                end
                done = 1'b1;
            end
            tick();
        end
        bready = 1'b0;
        finish_test(ent_name[idx], errs_before);
    endtask

    task automatic collect_rresp(input int idx, input int errs_before);
        logic done;
        done = 1'b0;
        while (!done) begin
            rready = ($urandom % 4) != 0;
            if (rvalid && rready) begin
                if (rid !== ent_id[idx]) begin
                    report_mismatch(ent_name[idx], "rid", ent_id[idx], rid);
                end
                if (rdata !== expected_word(idx)) begin
                    report_mismatch(ent_name[idx], "rdata", expected_word(idx), rdata);
                end
                done = 1'b1;
            end
            tick();
        end
        rready = 1'b0;
        finish_test(ent_name[idx], errs_before);
    endtask

    ////////////////////////////////////////
    // Stalled batches
    ////////////////////////////////////////

    task automatic run_held_writes(input int first, input int last);
        int              errs_before;
        int              accepted;
        logic            ok;
        logic [ID_W-1:0] held_bid;
        errs_before = errors;
        accepted    = 0;
        bready      = 1'b0;
        send_write(first, ok);
        if (!ok) begin
            report_error(ent_name[first], "first write of the batch was not accepted");
        end
        while (!bvalid) begin
            tick();
        end
        held_bid = bid;
        accepted = 1;
        for (int k = first + 1; k < last; k++) begin
            send_write(k, ok);
            if (!ok) begin
                if (accepted < OSTD_REQ_NUM + 1) begin
                    report_error(ent_name[k], "awready fell before the write FIFOs were full");
                end
                break;
            end
            accepted++;
            if (!bvalid) begin
                report_error(ent_name[k], "bvalid dropped while bready was low");
            end
            if (bid !== held_bid) begin
                report_mismatch(ent_name[k], "held bid", held_bid, bid);
            end
            // The committed write has left the FIFOs, the rest still wait there
            if (accepted < OSTD_REQ_NUM + 1 && !awready) begin
                report_error(ent_name[k], "awready low while the write FIFOs have space");
            end
        end
        repeat (2) begin
            tick();
            if (!bvalid) begin
                report_error(ent_name[first], "bvalid dropped while bready was low");
            end
            if (bid !== held_bid) begin
                report_mismatch(ent_name[first], "held bid", held_bid, bid);
            end
        end
        // Responses after the release come back in issue order
        collect_bresp(first, errs_before);
        for (int k = first + 1; k < first + accepted; k++) begin
            collect_bresp(k, errors);
        end
    endtask

    task automatic run_held_reads(input int first, input int last);
        int                errs_before;
        int                accepted;
        logic              ok;
        logic [ID_W-1:0]   head_id;
        logic [DATA_W-1:0] head_data;
        errs_before = errors;
        accepted    = 0;
        rready      = 1'b0;
        for (int k = first; k < last; k++) begin
            send_read(k, ok);
            if (!ok) begin
                report_error(ent_name[k], "read address not accepted while rready was low");
                break;
            end
            accepted++;
            if (accepted < OSTD_REQ_NUM && !arready) begin
                report_error(ent_name[k], "arready fell before the read FIFO was full");
            end
            if (accepted >= OSTD_REQ_NUM && arready) begin
                report_error(ent_name[k], "arready still high with a full read FIFO");
            end
        end
        if (!rvalid) begin
            report_error(ent_name[first], "rvalid low with reads queued");
        end
        head_id   = rid;
        head_data = rdata;
        repeat (2) begin
            tick();
            if (rid !== head_id) begin
                report_mismatch(ent_name[first], "held rid", head_id, rid);
            end
            if (rdata !== head_data) begin
                report_mismatch(ent_name[first], "held rdata", head_data, rdata);
            end
        end
        collect_rresp(first, errs_before);
        for (int k = first + 1; k < first + accepted; k++) begin
            collect_rresp(k, errors);
        end
    endtask

    task automatic check_reset_state();
        int errs_before;
        errs_before = errors;
        if (bvalid !== 1'b0) begin
            report_mismatch("reset_state", "bvalid", 1'b0, bvalid);
        end
        if (rvalid !== 1'b0) begin
            report_mismatch("reset_state", "rvalid", 1'b0, rvalid);
        end
        if (awready !== 1'b1) begin
            report_mismatch("reset_state", "awready", 1'b1, awready);
        end
        if (wready !== 1'b1) begin
            report_mismatch("reset_state", "wready", 1'b1, wready);
        end
        if (arready !== 1'b1) begin
            report_mismatch("reset_state", "arready", 1'b1, arready);
        end
        finish_test("reset_state", errs_before);
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        int   idx;
        int   run_end;
        int   errs_before;
        logic ok;
        void'($urandom(32'hd26));
        aresetn  = 1'b0;
        awvalid  = 1'b0;
        awaddr   = '0;
        awid     = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        arid     = '0;
        rready   = 1'b0;
        fill_table();
        repeat (5) @(posedge aclk);
        #DRIVE_DLY;
        aresetn = 1'b1;
        tick();
        check_reset_state();

        idx = 0;
        while (idx < NUM_ENTRIES) begin
            errs_before = errors;
            case (ent_op[idx])
                OP_WR: begin
                    send_write(idx, ok);
                    if (ok) begin
                        collect_bresp(idx, errs_before);
                    end else begin
                        report_error(ent_name[idx], "write address and data not accepted");
                        finish_test(ent_name[idx], errs_before);
                    end
                    idx++;
                end
                OP_RD: begin
                    send_read(idx, ok);
                    if (ok) begin
                        collect_rresp(idx, errs_before);
                    end else begin
                        report_error(ent_name[idx], "read address not accepted");
                        finish_test(ent_name[idx], errs_before);
                    end
                    idx++;
                end
                default: begin
                    // Group consecutive entries of the same stalled kind
                    run_end = idx;
                    while (run_end < NUM_ENTRIES && ent_op[run_end] == ent_op[idx]) begin
                        run_end++;
                    end
                    if (ent_op[idx] == OP_WR_HELD) begin
                        run_held_writes(idx, run_end);
                    end else begin
                        run_held_reads(idx, run_end);
                    end
                    idx = run_end;
                end
            endcase
        end

        $display("Tests run: %0d, failed checks: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Free-running clock for the testbench
// PERIOD is the full clock period in ns

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 4
) (
    output logic aclk
);

    initial begin
        aclk = 1'b0;
    end

    always begin
        #(PERIOD / 2.0);
        aclk = ~aclk;
    end

endmodule

`default_nettype wire

/* vlog.f */
axil_ram_pkg.sv
ram_wr_if.sv
req_fifo.sv
write_path.sv
read_path.sv
line_ram.sv
axil_ram.sv
tb_clk_gen.sv
tb_axil_ram.sv

/* write_path.sv */
// AXI4-lite write side that queues AW and W beats, pairs them into RAM commits
// and returns one B response per commit with the request's ID

`timescale 1ns/1ps
`default_nettype none

module write_path
    import axil_ram_pkg::*;
#(
    parameter int ADDR_W       = axil_ram_pkg::ADDR_W,
    parameter int ID_W         = axil_ram_pkg::ID_W,
    parameter int OSTD_REQ_NUM = axil_ram_pkg::OSTD_REQ_NUM
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              awvalid,
    output logic              awready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic [ID_W-1:0]   awid,
    input  logic              wvalid,
    output logic              wready,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    output logic              bvalid,
    input  logic              bready,
    output logic [ID_W-1:0]   bid,
    ram_wr_if.src             wr
);

    logic              aw_full;
    logic              aw_empty;
    logic [ADDR_W-1:0] aw_addr_head;
    logic [ID_W-1:0]   aw_id_head;
    logic              w_full;
    logic              w_empty;
    logic [DATA_W-1:0] w_data_head;
    logic [STRB_W-1:0] w_strb_head;
    logic              commit;

    // Both channels stall together as soon as either queue fills
    assign awready = !aw_full && !w_full;
    assign wready  = awready;

    req_fifo #(
        .WIDTH (ID_W + ADDR_W),
        .DEPTH (OSTD_REQ_NUM)
    ) u_aw_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (awvalid && awready),
        .data_in  ({awid, awaddr}),
        .full     (aw_full),
        .pull     (commit),
        .data_out ({aw_id_head, aw_addr_head}),
        .empty    (aw_empty)
    );

    req_fifo #(
        .WIDTH (STRB_W + DATA_W),
        .DEPTH (OSTD_REQ_NUM)
    ) u_w_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (wvalid && wready),
        .data_in  ({wstrb, wdata}),
        .full     (w_full),
        .pull     (commit),
        .data_out ({w_strb_head, w_data_head}),
        .empty    (w_empty)
    );

    ////////////////////////////////////////
    // Commit and response
    ////////////////////////////////////////

    // Only one write in flight between the commit pulse and its response
    assign commit = !aw_empty && !w_empty && !bvalid && !wr.wr_en;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr.wr_en <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            wr.wr_en <= commit;
            if (wr.wr_en) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Heads are captured at the commit edge while the FIFOs pop
    always_ff @(posedge aclk) begin
        if (commit) begin
            wr.wr_addr <= aw_addr_head;
            wr.wr_data <= w_data_head;
            wr.wr_strb <= w_strb_head;
            bid        <= aw_id_head;
        end
    end

    // Pending response holds until the master accepts it
    b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid && !bready |=> bvalid && $stable(bid));

endmodule

`default_nettype wire
